// File: common/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// Activation and weight width, signed
`define CONV_DAT_W 8

// Geometry of one row slice
`define CONV_NUM_CH 3
`define CONV_NUM_POS 3
`define CONV_NUM_KN 4

// Dot product accumulator
`define CONV_ACC_W 20

// Ingress FIFO depths, equal to the sender credit allowance
`define CONV_WGT_CREDITS 4
`define CONV_PIX_CREDITS 2

`endif

// File: common/conv_pkg.sv
`include "conv_settings.svh"

package conv_pkg;

    // One weight beat: kernel index plus three channel bytes
    typedef struct packed {
        logic [$clog2(`CONV_NUM_KN)-1:0]                kn;
        logic [`CONV_NUM_CH-1:0][`CONV_DAT_W-1:0]       ch;
    } wgt_beat_t;

    // One pixel beat, last marks the end of a row
    typedef struct packed {
        logic [`CONV_NUM_CH-1:0][`CONV_DAT_W-1:0]       ch;
        logic                                           last;
    } pix_beat_t;

    // Sliding window, pos[0] is the oldest pixel
    typedef struct packed {
        logic [`CONV_NUM_POS-1:0][`CONV_NUM_CH-1:0][`CONV_DAT_W-1:0] pos;
        logic                                                         last;
    } pix_window_t;

    // One kernel, pos[0] is the first beat loaded
    typedef struct packed {
        logic [`CONV_NUM_POS-1:0][`CONV_NUM_CH-1:0][`CONV_DAT_W-1:0] pos;
    } kn_weights_t;

    typedef struct packed {
        kn_weights_t [`CONV_NUM_KN-1:0] kn;
    } wgt_set_t;

    // Four signed dot products
    typedef struct packed {
        logic [`CONV_NUM_KN-1:0][`CONV_ACC_W-1:0]       sum;
        logic                                           last;
    } conv_result_t;

    // Row controller
    typedef enum logic {
        WAIT_WGT,
        RUN
    } row_state_e;

endpackage

// File: weight_buffer/weight_buffer.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module weight_buffer import conv_pkg::*; (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [`CONV_NUM_KN-1:0]                 i_kn_valid,
    input  logic [`CONV_NUM_CH*`CONV_DAT_W-1:0]     i_kn_data,
    input  logic                                    i_data_req,
    output wgt_set_t                                o_wgts,
    output logic [`CONV_NUM_KN-1:0]                 o_kn_full,
    output logic                                    o_full
);

    localparam int BEAT_W = `CONV_NUM_CH * `CONV_DAT_W;

    ////////////////////
    // Per-kernel lanes
    ////////////////////

    genvar k;
    generate
        for (k = 0; k < `CONV_NUM_KN; k++) begin : g_lane
            logic [BEAT_W-1:0]        data_q [`CONV_NUM_POS];
            logic [`CONV_NUM_POS-1:0] val_q;

            // Newest beat enters at slot 0
            always_ff @(posedge clk) begin
                if (i_kn_valid[k]) begin
                    data_q[0] <= i_kn_data;
                    for (int p = 1; p < `CONV_NUM_POS; p++) begin
                        data_q[p] <= data_q[p-1];
                    end
                end
            end

            // Valid bits follow the data, cleared when the set is handed over
            always_ff @(posedge clk) begin
                if (rst || i_data_req) begin
                    val_q <= '0;
                end else if (i_kn_valid[k]) begin
                    val_q <= {val_q[`CONV_NUM_POS-2:0], 1'b1};
                end
            end

            assign o_kn_full[k] = &val_q;

            // Oldest slot holds the first beat, so reverse for position order
            for (genvar p = 0; p < `CONV_NUM_POS; p++) begin : g_pos
                assign o_wgts.kn[k].pos[p] = data_q[`CONV_NUM_POS-1-p];
            end
        end
    endgenerate

    assign o_full = &o_kn_full;

    ////////////////////
    // Checks
    ////////////////////

    // Controller only requests a complete set
    a_req_when_full: assert property (
        @(posedge clk) disable iff (rst)
        i_data_req |-> o_full
    );

    // Loader holds back a lane that is already full
    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst)
        (i_kn_valid & o_kn_full) == '0
    );

endmodule

// File: verilog/weight_loader.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module weight_loader import conv_pkg::*; (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    i_wgt_valid,
    input  wgt_beat_t                               i_wgt,
    input  logic [`CONV_NUM_KN-1:0]                 i_kn_full,
    output logic [`CONV_NUM_KN-1:0]                 o_kn_valid,
    output logic [`CONV_NUM_CH*`CONV_DAT_W-1:0]     o_kn_data,
    output logic                                    o_wgt_credit
);

    localparam int DEPTH = `CONV_WGT_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    wgt_beat_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    wgt_beat_t        head;
    logic             pop;

    ////////////////////
    // Ingress FIFO
    ////////////////////

    always_ff @(posedge clk) begin
        if (i_wgt_valid) begin
            mem[wr_ptr] <= i_wgt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wgt_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(i_wgt_valid) - CNT_W'(pop);
        end
    end

    ////////////////////
    // Lane steering
    ////////////////////

    assign head = mem[rd_ptr];

    // Head waits while its kernel lane is full
    assign pop = (count != '0) && !i_kn_full[head.kn];

    always_comb begin
        o_kn_valid = '0;
        if (pop) begin
            o_kn_valid[head.kn] = 1'b1;
        end
    end

    assign o_kn_data    = head.ch;
    assign o_wgt_credit = pop;

    // Sender must hold a credit for every beat
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        i_wgt_valid |-> count != CNT_W'(DEPTH)
    );

endmodule

// File: verilog/pixel_window.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module pixel_window import conv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_pix_valid,
    input  pix_beat_t   i_pix,
    input  logic        i_win_take,
    output logic        o_win_valid,
    output pix_window_t o_win,
    output logic        o_pix_credit
);

    localparam int DEPTH = `CONV_PIX_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int FIL_W = $clog2(`CONV_NUM_POS + 1);

    pix_beat_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [FIL_W-1:0] fill;
    logic             pop;
    logic             flush;

    ////////////////////
    // Ingress FIFO
    ////////////////////

    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            mem[wr_ptr] <= i_pix;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_pix_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(i_pix_valid) - CNT_W'(pop);
        end
    end

    ////////////////////
    // Sliding window
    ////////////////////

    assign o_win_valid = (fill == FIL_W'(`CONV_NUM_POS));

    // Taking the last window of a row empties it
    assign flush = i_win_take && o_win.last;

    // Refill while short, or slide on a take
    assign pop = (count != '0) && (!o_win_valid || i_win_take) && !flush;

    // Every pop shifts, taking alone only retires the oldest slot
    always_ff @(posedge clk) begin
        if (pop) begin
            for (int p = 0; p < `CONV_NUM_POS - 1; p++) begin
                o_win.pos[p] <= o_win.pos[p+1];
            end
            o_win.pos[`CONV_NUM_POS-1] <= mem[rd_ptr].ch;
            o_win.last                 <= mem[rd_ptr].last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            fill <= '0;
        end else begin
            fill <= fill + FIL_W'(pop) - FIL_W'(i_win_take);
        end
    end

    assign o_pix_credit = pop;

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        i_pix_valid |-> count != CNT_W'(DEPTH)
    );

endmodule

// File: verilog/conv_mac_array.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module conv_mac_array import conv_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  wgt_set_t     i_wgts,
    input  logic         i_wgt_full,
    input  logic         i_win_valid,
    input  pix_window_t  i_win,
    input  logic         i_out_credit,
    output logic         o_wgt_req,
    output logic         o_win_take,
    output logic         o_res_valid,
    output conv_result_t o_res
);

    localparam int PROD_W = 2 * `CONV_DAT_W;

    row_state_e              state;
    wgt_set_t                wgt_q;
    logic [7:0]              credit_q;
    logic signed [PROD_W-1:0] prod_q [`CONV_NUM_KN][`CONV_NUM_POS][`CONV_NUM_CH];
    logic                    s1_valid;
    logic                    s1_last;
    logic signed [`CONV_ACC_W-1:0] sum_d [`CONV_NUM_KN];

    ////////////////////
    // Row controller
    ////////////////////

    assign o_wgt_req  = (state == WAIT_WGT) && i_wgt_full;
    assign o_win_take = (state == RUN) && i_win_valid && (credit_q != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WAIT_WGT;
        end else if (o_wgt_req) begin
            state <= RUN;
        end else if (o_win_take && i_win.last) begin
            state <= WAIT_WGT;
        end
    end

    // Set stays fixed for the row while the buffer refills behind it
    always_ff @(posedge clk) begin
        if (o_wgt_req) begin
            wgt_q <= i_wgts;
        end
    end

    // Output credits with one spent per window
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_q <= '0;
        end else begin
            credit_q <= credit_q + 8'(i_out_credit) - 8'(o_win_take);
        end
    end

    ////////////////////
    // Stage 1 products
    ////////////////////

    always_ff @(posedge clk) begin
        if (o_win_take) begin
            for (int k = 0; k < `CONV_NUM_KN; k++) begin
                for (int p = 0; p < `CONV_NUM_POS; p++) begin
                    for (int c = 0; c < `CONV_NUM_CH; c++) begin
                        prod_q[k][p][c] <= $signed(wgt_q.kn[k].pos[p][c])
                                         * $signed(i_win.pos[p][c]);
                    end
                end
            end
            s1_last <= i_win.last;
        end
    end

    ////////////////////
    // Stage 2 sums
    ////////////////////

    always_comb begin
        for (int k = 0; k < `CONV_NUM_KN; k++) begin
            sum_d[k] = '0;
            for (int p = 0; p < `CONV_NUM_POS; p++) begin
                for (int c = 0; c < `CONV_NUM_CH; c++) begin
                    sum_d[k] = sum_d[k] + `CONV_ACC_W'(prod_q[k][p][c]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int k = 0; k < `CONV_NUM_KN; k++) begin
                o_res.sum[k] <= sum_d[k];
            end
            o_res.last <= s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            o_res_valid <= 1'b0;
        end else begin
            s1_valid    <= o_win_take;
            o_res_valid <= s1_valid;
        end
    end

    // Downstream never grants past the counter range
    a_credit_range: assert property (
        @(posedge clk) disable iff (rst)
        (credit_q == '1 && i_out_credit) |-> o_win_take
    );

    // Empty counter stays empty until downstream grants
    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        (credit_q == '0 && !i_out_credit) |=> credit_q == '0
    );

endmodule

// File: verilog/conv_row_top.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module conv_row_top import conv_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    // Weight stream
    input  logic         i_wgt_valid,
    input  wgt_beat_t    i_wgt,
    output logic         o_wgt_credit,
    // Pixel stream
    input  logic         i_pix_valid,
    input  pix_beat_t    i_pix,
    output logic         o_pix_credit,
    // Result stream
    input  logic         i_out_credit,
    output logic         o_res_valid,
    output conv_result_t o_res
);

    logic [`CONV_NUM_KN-1:0]             kn_valid;
    logic [`CONV_NUM_CH*`CONV_DAT_W-1:0] kn_data;
    logic [`CONV_NUM_KN-1:0]             kn_full;
    logic                                wgt_full;
    logic                                wgt_req;
    wgt_set_t                            wgts;
    logic                                win_valid;
    logic                                win_take;
    pix_window_t                         win;

    ////////////////////
    // Weight path
    ////////////////////

    weight_loader u_loader (
        .clk          (clk),
        .rst          (rst),
        .i_wgt_valid  (i_wgt_valid),
        .i_wgt        (i_wgt),
        .i_kn_full    (kn_full),
        .o_kn_valid   (kn_valid),
        .o_kn_data    (kn_data),
        .o_wgt_credit (o_wgt_credit)
    );

    weight_buffer u_wbuf (
        .clk        (clk),
        .rst        (rst),
        .i_kn_valid (kn_valid),
        .i_kn_data  (kn_data),
        .i_data_req (wgt_req),
        .o_wgts     (wgts),
        .o_kn_full  (kn_full),
        .o_full     (wgt_full)
    );

    ////////////////////
    // Pixel path and MAC
    ////////////////////

    pixel_window u_window (
        .clk          (clk),
        .rst          (rst),
        .i_pix_valid  (i_pix_valid),
        .i_pix        (i_pix),
        .i_win_take   (win_take),
        .o_win_valid  (win_valid),
        .o_win        (win),
        .o_pix_credit (o_pix_credit)
    );

    conv_mac_array u_mac (
        .clk          (clk),
        .rst          (rst),
        .i_wgts       (wgts),
        .i_wgt_full   (wgt_full),
        .i_win_valid  (win_valid),
        .i_win        (win),
        .i_out_credit (i_out_credit),
        .o_wgt_req    (wgt_req),
        .o_win_take   (win_take),
        .o_res_valid  (o_res_valid),
        .o_res        (o_res)
    );

endmodule

// File: testbench/tb_conv_row_top.sv
`timescale 1ns/1ps

`include "conv_settings.svh"

module tb_conv_row_top import conv_pkg::*; ();

    localparam int TIMEOUT  = 2000;
    localparam int N_JOBS   = 6;
    localparam int WGT_CRED = `CONV_WGT_CREDITS;
    localparam int PIX_CRED = `CONV_PIX_CREDITS;

    typedef enum logic {
        VAL_SMALL,
        VAL_EXTREME
    } val_mode_e;

    typedef enum logic [1:0] {
        CRED_UPFRONT,
        CRED_TRICKLE,
        CRED_DELAYED
    } cred_mode_e;

    // One row of the job table
    typedef struct packed {
        logic [31:0] seed;
        logic [7:0]  len;
        val_mode_e   vals;
        cred_mode_e  cred;
    } job_t;

    logic         clk;
    logic         rst;
    logic         i_wgt_valid;
    wgt_beat_t    i_wgt;
    logic         o_wgt_credit;
    logic         i_pix_valid;
    pix_beat_t    i_pix;
    logic         o_pix_credit;
    logic         i_out_credit;
    logic         o_res_valid;
    conv_result_t o_res;

    job_t         jobs [N_JOBS];
    wgt_beat_t    wgt_beats [$];
    pix_beat_t    pix_beats [$];
    conv_result_t exp_q [$];
    conv_result_t exp_res;
    int           wgt_sent;
    int           wgt_returned;
    int           pix_sent;
    int           pix_returned;
    int           out_granted;
    int           res_count;
    int           total_windows;
    int           mismatches;
    int           errors;
    bit           timed_out;

    conv_row_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .i_wgt_valid  (i_wgt_valid),
        .i_wgt        (i_wgt),
        .o_wgt_credit (o_wgt_credit),
        .i_pix_valid  (i_pix_valid),
        .i_pix        (i_pix),
        .o_pix_credit (o_pix_credit),
        .i_out_credit (i_out_credit),
        .o_res_valid  (o_res_valid),
        .o_res        (o_res)
    );

    always #4 clk = ~clk;

    ////////////////////
    // Stimulus and model
    ////////////////////

    task automatic fill_table();
        jobs[0] = '{32'h0000_1d2f, 8'd3,  VAL_SMALL,   CRED_UPFRONT};
        jobs[1] = '{32'h5a17_c3e1, 8'd8,  VAL_SMALL,   CRED_UPFRONT};
        jobs[2] = '{32'h9b04_66d2, 8'd6,  VAL_SMALL,   CRED_TRICKLE};
        jobs[3] = '{32'h3c8e_0f75, 8'd7,  VAL_EXTREME, CRED_DELAYED};
        jobs[4] = '{32'he2f1_4a09, 8'd5,  VAL_EXTREME, CRED_UPFRONT};
        jobs[5] = '{32'h7716_b8c4, 8'd10, VAL_SMALL,   CRED_TRICKLE};
    endtask

    // Weight hash so a table seed always gives the same set
    function automatic logic [31:0] mix(input logic [31:0] seed, input int idx);
        logic [31:0] h;
        h = seed ^ (32'(idx) * 32'h9e37_79b9);
        h = h ^ (h >> 15);
        h = h * 32'h2c1b_3c6d;
        return h ^ (h >> 12);
    endfunction

    // Small spans -8..7 and extreme is mostly -128 with some 127
    function automatic logic [7:0] map_value(input logic [31:0] r, input val_mode_e mode);
        if (mode == VAL_SMALL) begin
            return {{4{r[3]}}, r[3:0]};
        end
        return (r[2:0] != 3'd0) ? 8'h80 : 8'h7f;
    endfunction

    task automatic build_job(input int j);
        logic [7:0]   w [`CONV_NUM_KN][`CONV_NUM_POS][`CONV_NUM_CH];
        pix_beat_t    row [$];
        pix_beat_t    beat;
        wgt_beat_t    wb;
        conv_result_t res;
        int           acc;
        // First beat of each kernel is position 0
        for (int k = 0; k < `CONV_NUM_KN; k++) begin
            for (int p = 0; p < `CONV_NUM_POS; p++) begin
                wb.kn = 2'(k);
                for (int c = 0; c < `CONV_NUM_CH; c++) begin
                    w[k][p][c] = map_value(mix(jobs[j].seed, k * 9 + p * 3 + c), jobs[j].vals);
                    wb.ch[c]   = w[k][p][c];
                end
                wgt_beats.push_back(wb);
            end
        end
        for (int i = 0; i < jobs[j].len; i++) begin
            for (int c = 0; c < `CONV_NUM_CH; c++) begin
                beat.ch[c] = map_value($urandom, jobs[j].vals);
            end
            beat.last = (i == jobs[j].len - 1);
            row.push_back(beat);
            pix_beats.push_back(beat);
        end
        // Every window against every kernel
        for (int i = 0; i + `CONV_NUM_POS <= jobs[j].len; i++) begin
            for (int k = 0; k < `CONV_NUM_KN; k++) begin
                acc = 0;
                for (int p = 0; p < `CONV_NUM_POS; p++) begin
                    for (int c = 0; c < `CONV_NUM_CH; c++) begin
                        acc = acc + int'($signed(w[k][p][c])) * int'($signed(row[i+p].ch[c]));
                    end
                end
                res.sum[k] = `CONV_ACC_W'(acc);
            end
            res.last = (i + `CONV_NUM_POS == jobs[j].len);
            exp_q.push_back(res);
        end
    endtask

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_result(input conv_result_t got, input conv_result_t exp, input int idx);
        for (int k = 0; k < `CONV_NUM_KN; k++) begin
            if (got.sum[k] !== exp.sum[k]) begin
                $display("mismatch at %0t ns: result %0d kernel %0d got %0d expected %0d",
                         $time, idx, k, $signed(got.sum[k]), $signed(exp.sum[k]));
                mismatches++;
            end
        end
        if (got.last !== exp.last) begin
            $display("mismatch at %0t ns: result %0d last flag got %0b expected %0b",
                     $time, idx, got.last, exp.last);
            mismatches++;
        end
    endtask

    task automatic check_credit_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // Credit returns and results sampled at the edge
    always @(posedge clk) begin
        if (!rst) begin
            if (o_wgt_credit) begin
                if (wgt_returned >= wgt_sent) begin
                    $display("weight credit returned at %0t ns with no beat outstanding", $time);
                    errors++;
                end
                wgt_returned++;
            end
            if (o_pix_credit) begin
                if (pix_returned >= pix_sent) begin
                    $display("pixel credit returned at %0t ns with no beat outstanding", $time);
                    errors++;
                end
                pix_returned++;
            end
            if (o_res_valid) begin
                if (res_count >= out_granted) begin
                    $display("result at %0t ns was issued without an output credit", $time);
                    errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("result at %0t ns arrived when none was expected", $time);
                    errors++;
                end else begin
                    exp_res = exp_q.pop_front();
                    check_result(o_res, exp_res, res_count);
                end
                res_count++;
            end
        end
    end

    ////////////////////
    // Senders and waits
    ////////////////////

    task automatic send_weights();
        int idx;
        int stall;
        idx   = 0;
        stall = 0;
        while (idx < wgt_beats.size() && !timed_out) begin
            @(posedge clk);
            #1;
            if (wgt_sent - wgt_returned < WGT_CRED) begin
                i_wgt_valid = 1'b1;
                i_wgt       = wgt_beats[idx];
                wgt_sent++;
                idx++;
                stall = 0;
            end else begin
                i_wgt_valid = 1'b0;
                stall++;
                if (stall > TIMEOUT) begin
                    $display("timeout: no weight credit came back for beat %0d", idx);
                    errors++;
                    timed_out = 1'b1;
                end
            end
        end
        @(posedge clk);
        #1;
        i_wgt_valid = 1'b0;
    endtask

    task automatic send_pixels();
        int idx;
        int stall;
        idx   = 0;
        stall = 0;
        while (idx < pix_beats.size() && !timed_out) begin
            @(posedge clk);
            #1;
            if (pix_sent - pix_returned < PIX_CRED) begin
                i_pix_valid = 1'b1;
                i_pix       = pix_beats[idx];
                pix_sent++;
                idx++;
                stall = 0;
            end else begin
                i_pix_valid = 1'b0;
                stall++;
                if (stall > TIMEOUT) begin
                    $display("timeout: no pixel credit came back for beat %0d", idx);
                    errors++;
                    timed_out = 1'b1;
                end
            end
        end
        @(posedge clk);
        #1;
        i_pix_valid = 1'b0;
    endtask

    task automatic wait_results(input int target);
        int cyc;
        cyc = 0;
        while (res_count < target && !timed_out) begin
            @(posedge clk);
            cyc++;
            if (cyc > TIMEOUT) begin
                $display("timeout: only %0d of %0d results arrived", res_count, target);
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_credits();
        int cyc;
        cyc = 0;
        while ((wgt_returned != wgt_sent || pix_returned != pix_sent) && !timed_out) begin
            @(posedge clk);
            cyc++;
            if (cyc > TIMEOUT) begin
                $display("timeout: input credits were never fully returned");
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    // A row's output credits wait until the previous row has drained
    task automatic grant_credits();
        int base;
        int n;
        base = 0;
        for (int j = 0; j < N_JOBS; j++) begin
            n = jobs[j].len - (`CONV_NUM_POS - 1);
            wait_results(base);
            if (jobs[j].cred == CRED_DELAYED) begin
                repeat (30) @(posedge clk);
            end
            for (int i = 0; i < n && !timed_out; i++) begin
                @(posedge clk);
                #1;
                i_out_credit = 1'b1;
                out_granted++;
                if (jobs[j].cred == CRED_TRICKLE) begin
                    @(posedge clk);
                    #1;
                    i_out_credit = 1'b0;
                    repeat (3) @(posedge clk);
                end
            end
            @(posedge clk);
            #1;
            i_out_credit = 1'b0;
            base += n;
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        void'($urandom(32'hc84146bf));
        clk          = 1'b0;
        rst          = 1'b1;
        i_wgt_valid  = 1'b0;
        i_wgt        = '0;
        i_pix_valid  = 1'b0;
        i_pix        = '0;
        i_out_credit = 1'b0;
        fill_table();
        for (int j = 0; j < N_JOBS; j++) begin
            build_job(j);
        end
        total_windows = exp_q.size();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle DUT stays silent
        repeat (12) @(posedge clk);
        check_credit_count("weight credits after reset", wgt_returned, 0);
        check_credit_count("pixel credits after reset", pix_returned, 0);
        check_credit_count("results after reset", res_count, 0);

        // Next row's weights stream in while the current row runs
        fork
            send_weights();
            send_pixels();
            grant_credits();
            wait_results(total_windows);
        join
        wait_credits();
        repeat (10) @(posedge clk);

        check_credit_count("weight beats sent", wgt_sent, wgt_beats.size());
        check_credit_count("weight credits returned", wgt_returned, wgt_sent);
        check_credit_count("pixel beats sent", pix_sent, pix_beats.size());
        check_credit_count("pixel credits returned", pix_returned, pix_sent);
        check_credit_count("output credits spent", res_count, out_granted);
        check_credit_count("results received", res_count, total_windows);

        $display("summary: %0d results, %0d mismatches, %0d other errors",
                 res_count, mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: conv_row_top.f
+incdir+common
common/conv_pkg.sv
weight_buffer/weight_buffer.sv
verilog/weight_loader.sv
verilog/pixel_window.sv
verilog/conv_mac_array.sv
verilog/conv_row_top.sv
testbench/tb_conv_row_top.sv

// File: Bender.yml
package:
  name: conv_row

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/conv_pkg.sv
      - weight_buffer/weight_buffer.sv
      - verilog/weight_loader.sv
      - verilog/pixel_window.sv
      - verilog/conv_mac_array.sv
      - verilog/conv_row_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_conv_row_top.sv
